// ==== source/vrf_pkg.sv ====
// Geometry, data types and port indices of the vector register file; import where needed
package vrf_pkg;

  ////////////////////
  // Geometry
  ////////////////////

  // Bits per vector register
  localparam int unsigned VLEN = 256;

  // Architectural vector registers
  localparam int unsigned NRVREG = 32;

  // Each bank holds one word slice of every register
  localparam int unsigned NrVRFBanks     = 4;
  localparam int unsigned NrWordsPerBank = NRVREG;

  // Requesters seen by the file
  localparam int unsigned NrWritePorts = 3;
  localparam int unsigned NrReadPorts  = 5;

  // Physical read ports on every bank
  localparam int unsigned NrReadPortsPerBank = 3;

  ////////////////////
  // Types
  ////////////////////

  // One bank word and its byte enables
  typedef logic [VLEN/NrVRFBanks-1:0]   vreg_data_t;
  typedef logic [VLEN/NrVRFBanks/8-1:0] vreg_be_t;

  // Word index inside a bank, and bank number
  typedef logic [$clog2(NrWordsPerBank)-1:0] vreg_idx_t;
  typedef logic [$clog2(NrVRFBanks)-1:0]     bank_idx_t;

  // Full word address, bank field in the low bits
  typedef struct packed {
    vreg_idx_t vreg;
    bank_idx_t bank;
  } vreg_addr_t;

  // Write requesters, the value is also the priority (0 wins)
  typedef enum logic [1:0] {
    VFU_VD_WD   = 2'd0,
    VLSU_VD_WD  = 2'd1,
    VSLDU_VD_WD = 2'd2
  } vrf_wport_e;

  // Read requesters
  typedef enum logic [2:0] {
    VFU_VS2_RD   = 3'd0,
    VFU_VS1_RD   = 3'd1,
    VFU_VD_RD    = 3'd2,
    VLSU_VD_RD   = 3'd3,
    VSLDU_VS2_RD = 3'd4
  } vrf_rport_e;

  // One write request as it arrives at the file
  typedef struct packed {
    vreg_addr_t addr;
    vreg_data_t data;
    vreg_be_t   be;
  } vrf_wreq_t;

endpackage : vrf_pkg

// ==== source/vreg_bank.sv ====
// Flip-flop storage bank with one byte-masked write port and combinational read ports
module vreg_bank #(
  parameter int unsigned NrWords     = 32,
  parameter int unsigned NrReadPorts = 3
) (
  input  logic                                    clk_i,
  input  logic                                    rst_i,
  // Write port
  input  vrf_pkg::vreg_idx_t                      waddr_i,
  input  vrf_pkg::vreg_data_t                     wdata_i,
  input  logic                                    we_i,
  input  vrf_pkg::vreg_be_t                       wbe_i,
  // Read ports
  input  vrf_pkg::vreg_idx_t  [NrReadPorts-1:0]   raddr_i,
  output vrf_pkg::vreg_data_t [NrReadPorts-1:0]   rdata_o
);

  import vrf_pkg::*;

  localparam int unsigned NrBytes = $bits(vreg_be_t);

  ////////////////////
  // Storage
  ////////////////////

  vreg_data_t [NrWords-1:0] mem_q;

  // Only bytes with their enable set are updated
  always_ff @(posedge clk_i) begin : proc_mem
    if (rst_i) begin
      mem_q <= '0;
    end else if (we_i) begin
      for (int unsigned b = 0; b < NrBytes; b++) begin
        if (wbe_i[b]) begin
          mem_q[waddr_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  ////////////////////
  // Read ports
  ////////////////////

  // Reads see the stored value, so a same-cycle write is not forwarded
  for (genvar p = 0; p < NrReadPorts; p++) begin : gen_rd
    assign rdata_o[p] = mem_q[raddr_i[p]];
  end

  ////////////////////
  // Checks
  ////////////////////

  if (NrWords > 2 ** $bits(vreg_idx_t)) begin : gen_words_chk
    $error("vreg_bank: NrWords exceeds the range of the word index");
  end

  if (NrReadPorts < 1) begin : gen_rport_chk
    $error("vreg_bank: at least one read port is needed");
  end

  if ($bits(vreg_data_t) != 8 * NrBytes) begin : gen_be_chk
    $error("vreg_bank: one byte enable per data byte expected");
  end

  // An unknown write enable would corrupt the bank silently
  a_we_known : assert property (
    @(posedge clk_i) disable iff (rst_i) !$isunknown(we_i)
  ) else $error("vreg_bank: write enable is unknown");

endmodule : vreg_bank

// ==== source/vrf_write_arb.sv ====
// Fixed-priority write arbiter; routes each bank's winning write request and returns grants
module vrf_write_arb (
  input  logic                [vrf_pkg::NrWritePorts-1:0] we_i,
  input  vrf_pkg::vrf_wreq_t  [vrf_pkg::NrWritePorts-1:0] wreq_i,
  output logic                [vrf_pkg::NrWritePorts-1:0] wvalid_o,
  // Bank write ports
  output vrf_pkg::vreg_idx_t  [vrf_pkg::NrVRFBanks-1:0]   bank_waddr_o,
  output vrf_pkg::vreg_data_t [vrf_pkg::NrVRFBanks-1:0]   bank_wdata_o,
  output vrf_pkg::vreg_be_t   [vrf_pkg::NrVRFBanks-1:0]   bank_wbe_o,
  output logic                [vrf_pkg::NrVRFBanks-1:0]   bank_we_o
);

  import vrf_pkg::*;

  ////////////////////
  // Bank decode
  ////////////////////

  logic [NrVRFBanks-1:0][NrWritePorts-1:0] wreq_hit;
  logic [NrVRFBanks-1:0][NrWritePorts-1:0] wgrant;

  for (genvar bank = 0; bank < NrVRFBanks; bank++) begin : gen_bank_hit
    for (genvar port = 0; port < NrWritePorts; port++) begin : gen_port_hit
      assign wreq_hit[bank][port] = we_i[port] &&
                                    (wreq_i[port].addr.bank == bank_idx_t'(bank));
    end
  end

  ////////////////////
  // Priority select
  ////////////////////

  // Port order is the priority order: VFU, then VLSU, then slide unit
  always_comb begin : proc_wgrant
    wgrant = '0;
    for (int unsigned bank = 0; bank < NrVRFBanks; bank++) begin
      for (int unsigned port = 0; port < NrWritePorts; port++) begin
        if (wreq_hit[bank][port] && (wgrant[bank] == '0)) begin
          wgrant[bank][port] = 1'b1;
        end
      end
    end
  end

  // Steer the winner to its bank
  always_comb begin : proc_bank_mux
    bank_waddr_o = '0;
    bank_wdata_o = '0;
    bank_wbe_o   = '0;
    bank_we_o    = '0;
    wvalid_o     = '0;
    for (int unsigned bank = 0; bank < NrVRFBanks; bank++) begin
      for (int unsigned port = 0; port < NrWritePorts; port++) begin
        if (wgrant[bank][port]) begin
          bank_waddr_o[bank] = wreq_i[port].addr.vreg;
          bank_wdata_o[bank] = wreq_i[port].data;
          bank_wbe_o[bank]   = wreq_i[port].be;
        end
      end
      bank_we_o[bank] = |wgrant[bank];
      wvalid_o        = wvalid_o | wgrant[bank];
    end
  end

  ////////////////////
  // Checks
  ////////////////////

  // A granted requester must be the one its own bank is writing
  always_comb begin : proc_grant_chk
    bank_idx_t sel;
    for (int unsigned port = 0; port < NrWritePorts; port++) begin
      sel = wreq_i[port].addr.bank;
      a_grant_bank : assert (!wvalid_o[port] ||
                             (bank_we_o[sel] &&
                              (bank_waddr_o[sel] == wreq_i[port].addr.vreg) &&
                              (bank_wdata_o[sel] == wreq_i[port].data) &&
                              (bank_wbe_o[sel] == wreq_i[port].be)))
        else $error("vrf_write_arb: port %0d granted but bank %0d not carrying it", port, sel);
    end
  end

endmodule : vrf_write_arb

// ==== source/vrf_read_arb.sv ====
// Fixed-table read arbiter; shares each bank's three read ports among five read requesters
module vrf_read_arb (
  input  logic                [vrf_pkg::NrReadPorts-1:0]  re_i,
  input  vrf_pkg::vreg_addr_t [vrf_pkg::NrReadPorts-1:0]  raddr_i,
  // Bank read ports
  output vrf_pkg::vreg_idx_t  [vrf_pkg::NrVRFBanks-1:0][vrf_pkg::NrReadPortsPerBank-1:0]
                              bank_raddr_o,
  input  vrf_pkg::vreg_data_t [vrf_pkg::NrVRFBanks-1:0][vrf_pkg::NrReadPortsPerBank-1:0]
                              bank_rdata_i,
  // Requester returns
  output vrf_pkg::vreg_data_t [vrf_pkg::NrReadPorts-1:0]  rdata_o,
  output logic                [vrf_pkg::NrReadPorts-1:0]  rvalid_o
);

  import vrf_pkg::*;

  ////////////////////
  // Port table
  ////////////////////

  // Port 0: vs2 only. Port 1: vs1, then slide. Port 2: vd, then load/store
  localparam vrf_rport_e FirstReq [NrReadPortsPerBank] = '{
    VFU_VS2_RD, VFU_VS1_RD, VFU_VD_RD
  };
  localparam vrf_rport_e SecondReq [NrReadPortsPerBank] = '{
    VFU_VS2_RD, VSLDU_VS2_RD, VLSU_VD_RD
  };

  // Bank port 0 has no second requester
  localparam logic [NrReadPortsPerBank-1:0] HasSecond = 3'b110;

  ////////////////////
  // Bank decode
  ////////////////////

  logic [NrVRFBanks-1:0][NrReadPorts-1:0] rreq_hit;

  for (genvar bank = 0; bank < NrVRFBanks; bank++) begin : gen_bank_hit
    for (genvar port = 0; port < NrReadPorts; port++) begin : gen_port_hit
      assign rreq_hit[bank][port] = re_i[port] &&
                                    (raddr_i[port].bank == bank_idx_t'(bank));
    end
  end

  ////////////////////
  // Port select
  ////////////////////

  // Which of the two table entries owns each bank port this cycle
  logic [NrVRFBanks-1:0][NrReadPortsPerBank-1:0] use_first;
  logic [NrVRFBanks-1:0][NrReadPortsPerBank-1:0] use_second;

  always_comb begin : proc_rport_sel
    use_first    = '0;
    use_second   = '0;
    bank_raddr_o = '0;
    for (int unsigned bank = 0; bank < NrVRFBanks; bank++) begin
      for (int unsigned bp = 0; bp < NrReadPortsPerBank; bp++) begin
        if (rreq_hit[bank][FirstReq[bp]]) begin
          use_first[bank][bp]    = 1'b1;
          bank_raddr_o[bank][bp] = raddr_i[FirstReq[bp]].vreg;
        end else if (HasSecond[bp] && rreq_hit[bank][SecondReq[bp]]) begin
          use_second[bank][bp]   = 1'b1;
          bank_raddr_o[bank][bp] = raddr_i[SecondReq[bp]].vreg;
        end
      end
    end
  end

  ////////////////////
  // Data return
  ////////////////////

  // Ungranted requesters see zero
  always_comb begin : proc_rdata
    rdata_o  = '0;
    rvalid_o = '0;
    for (int unsigned bank = 0; bank < NrVRFBanks; bank++) begin
      for (int unsigned bp = 0; bp < NrReadPortsPerBank; bp++) begin
        if (use_first[bank][bp]) begin
          rdata_o[FirstReq[bp]]  = bank_rdata_i[bank][bp];
          rvalid_o[FirstReq[bp]] = 1'b1;
        end
        if (use_second[bank][bp]) begin
          rdata_o[SecondReq[bp]]  = bank_rdata_i[bank][bp];
          rvalid_o[SecondReq[bp]] = 1'b1;
        end
      end
    end
  end

  ////////////////////
  // Checks
  ////////////////////

  // The vs2 operand owns port 0 of every bank
  always_comb begin : proc_vs2_chk
    a_vs2_granted : assert (!re_i[VFU_VS2_RD] || rvalid_o[VFU_VS2_RD])
      else $error("vrf_read_arb: VFU_VS2_RD request not granted");
  end

endmodule : vrf_read_arb

// ==== source/vrf.sv ====
// Top of the banked vector register file; instantiate with write and read requester ports
module vrf (
  input  logic                                            clk_i,
  input  logic                                            rst_i,
  // Write requesters
  input  logic                [vrf_pkg::NrWritePorts-1:0] we_i,
  input  vrf_pkg::vrf_wreq_t  [vrf_pkg::NrWritePorts-1:0] wreq_i,
  output logic                [vrf_pkg::NrWritePorts-1:0] wvalid_o,
  // Read requesters
  input  logic                [vrf_pkg::NrReadPorts-1:0]  re_i,
  input  vrf_pkg::vreg_addr_t [vrf_pkg::NrReadPorts-1:0]  raddr_i,
  output vrf_pkg::vreg_data_t [vrf_pkg::NrReadPorts-1:0]  rdata_o,
  output logic                [vrf_pkg::NrReadPorts-1:0]  rvalid_o
);

  import vrf_pkg::*;

  ////////////////////
  // Bank wiring
  ////////////////////

  // Write side, one port per bank
  vreg_idx_t  [NrVRFBanks-1:0] bank_waddr;
  vreg_data_t [NrVRFBanks-1:0] bank_wdata;
  vreg_be_t   [NrVRFBanks-1:0] bank_wbe;
  logic       [NrVRFBanks-1:0] bank_we;

  // Read side, three ports per bank
  vreg_idx_t  [NrVRFBanks-1:0][NrReadPortsPerBank-1:0] bank_raddr;
  vreg_data_t [NrVRFBanks-1:0][NrReadPortsPerBank-1:0] bank_rdata;

  ////////////////////
  // Arbiters
  ////////////////////

  vrf_write_arb i_write_arb (
    .we_i         (we_i      ),
    .wreq_i       (wreq_i    ),
    .wvalid_o     (wvalid_o  ),
    .bank_waddr_o (bank_waddr),
    .bank_wdata_o (bank_wdata),
    .bank_wbe_o   (bank_wbe  ),
    .bank_we_o    (bank_we   )
  );

  vrf_read_arb i_read_arb (
    .re_i         (re_i      ),
    .raddr_i      (raddr_i   ),
    .bank_raddr_o (bank_raddr),
    .bank_rdata_i (bank_rdata),
    .rdata_o      (rdata_o   ),
    .rvalid_o     (rvalid_o  )
  );

  ////////////////////
  // Banks
  ////////////////////

  for (genvar bank = 0; bank < NrVRFBanks; bank++) begin : gen_banks
    vreg_bank #(
      .NrWords     (NrWordsPerBank    ),
      .NrReadPorts (NrReadPortsPerBank)
    ) i_bank (
      .clk_i   (clk_i           ),
      .rst_i   (rst_i           ),
      .waddr_i (bank_waddr[bank]),
      .wdata_i (bank_wdata[bank]),
      .we_i    (bank_we[bank]   ),
      .wbe_i   (bank_wbe[bank]  ),
      .raddr_i (bank_raddr[bank]),
      .rdata_o (bank_rdata[bank])
    );
  end

  ////////////////////
  // Geometry checks
  ////////////////////

  if (VLEN % (8 * NrVRFBanks) != 0) begin : gen_vlen_chk
    $error("vrf: VLEN must split into whole bytes on every bank");
  end

  if (NrWordsPerBank != NRVREG) begin : gen_words_chk
    $error("vrf: each bank must hold one word of every register");
  end

  if ($bits(vreg_addr_t) != $clog2(NRVREG) + $clog2(NrVRFBanks)) begin : gen_addr_chk
    $error("vrf: address width does not match the geometry");
  end

  if (NrReadPortsPerBank > NrReadPorts) begin : gen_rport_chk
    $error("vrf: more bank read ports than read requesters");
  end

  if (NrWritePorts < 1) begin : gen_wport_chk
    $error("vrf: at least one write requester is needed");
  end

endmodule : vrf

// ==== dv/vrf_model.svh ====
// Reference model of arbitration and storage for the register file, included inside the testbench
`ifndef VRF_MODEL_SVH
`define VRF_MODEL_SVH

// Expected bank contents, by register and bank
vreg_data_t model_mem [NRVREG][NrVRFBanks];

function automatic void model_clear();
  for (int unsigned r = 0; r < NRVREG; r++) begin
    for (int unsigned b = 0; b < NrVRFBanks; b++) begin
      model_mem[r][b] = '0;
    end
  end
endfunction

// A request loses to any enabled lower-numbered requester on the same bank
function automatic logic [NrWritePorts-1:0] model_wgrant(
  input logic      [NrWritePorts-1:0] we,
  input vrf_wreq_t [NrWritePorts-1:0] wreq
);
  logic [NrWritePorts-1:0] grant;
  grant = we;
  for (int unsigned p = 1; p < NrWritePorts; p++) begin
    for (int unsigned q = 0; q < p; q++) begin
      if (we[q] && (wreq[q].addr.bank == wreq[p].addr.bank)) begin
        grant[p] = 1'b0;
      end
    end
  end
  return grant;
endfunction

// Only the two shared bank ports can refuse a request
function automatic logic [NrReadPorts-1:0] model_rgrant(
  input logic       [NrReadPorts-1:0] re,
  input vreg_addr_t [NrReadPorts-1:0] raddr
);
  logic [NrReadPorts-1:0] grant;
  grant = re;
  if (re[VFU_VS1_RD] && (raddr[VFU_VS1_RD].bank == raddr[VSLDU_VS2_RD].bank)) begin
    grant[VSLDU_VS2_RD] = 1'b0;
  end
  if (re[VFU_VD_RD] && (raddr[VFU_VD_RD].bank == raddr[VLSU_VD_RD].bank)) begin
    grant[VLSU_VD_RD] = 1'b0;
  end
  return grant;
endfunction

// Ungranted ports return zero
function automatic vreg_data_t model_rdata(input logic granted, input vreg_addr_t addr);
  if (granted) begin
    return model_mem[addr.vreg][addr.bank];
  end
  return '0;
endfunction

// Applied after the clock edge, byte by byte
function automatic void model_write(
  input logic      [NrWritePorts-1:0] grant,
  input vrf_wreq_t [NrWritePorts-1:0] wreq
);
  for (int unsigned p = 0; p < NrWritePorts; p++) begin
    for (int unsigned b = 0; b < $bits(vreg_be_t); b++) begin
      if (grant[p] && wreq[p].be[b]) begin
        model_mem[wreq[p].addr.vreg][wreq[p].addr.bank][8*b +: 8] = wreq[p].data[8*b +: 8];
      end
    end
  end
endfunction

`endif

// ==== dv/vrf_tb.sv ====
// Testbench top for the vector register file; random traffic checked against a reference model
module vrf_tb;

  import vrf_pkg::*;

  ////////////////////
  // Run length
  ////////////////////

  localparam int unsigned ClkPeriod   = 20;
  localparam int unsigned DriveDelay  = 2;
  localparam int unsigned ResetCycles = 5;
  localparam int unsigned SweepCycles = NRVREG * NrVRFBanks;
  localparam int unsigned NumCycles   = 5000;
  // Reset, sweep and random phase plus a margin of 50 cycles
  localparam int unsigned TimeoutTime =
    (ResetCycles + SweepCycles + NumCycles + 50) * ClkPeriod;

  ////////////////////
  // DUT signals
  ////////////////////

  logic                             clk_i;
  logic                             rst_i;
  logic       [NrWritePorts-1:0]    we_i;
  vrf_wreq_t  [NrWritePorts-1:0]    wreq_i;
  logic       [NrWritePorts-1:0]    wvalid_o;
  logic       [NrReadPorts-1:0]     re_i;
  vreg_addr_t [NrReadPorts-1:0]     raddr_i;
  vreg_data_t [NrReadPorts-1:0]     rdata_o;
  logic       [NrReadPorts-1:0]     rvalid_o;

  logic [31:0] rng_state;

  // Event counts for the interesting cases
  int unsigned wr_conflicts;
  int unsigned rd_refusals;
  int unsigned same_word;

  `include "vrf_model.svh"

  vrf uut (
    .clk_i    (clk_i   ),
    .rst_i    (rst_i   ),
    .we_i     (we_i    ),
    .wreq_i   (wreq_i  ),
    .wvalid_o (wvalid_o),
    .re_i     (re_i    ),
    .raddr_i  (raddr_i ),
    .rdata_o  (rdata_o ),
    .rvalid_o (rvalid_o)
  );

  initial begin
    clk_i = 1'b0;
  end

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  ////////////////////
  // Helpers
  ////////////////////

  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic check_grant(input string name, input logic [NrReadPorts-1:0] got,
                             input logic [NrReadPorts-1:0] exp);
    if (got !== exp) begin
      $display("ERROR: %s is 0x%h, expected 0x%h at time %0t", name, got, exp, $time);
      $display("Test failed");
      $fatal(1, "Grant mismatch");
    end
  endtask

  task automatic check_data(input string name, input vreg_data_t got, input vreg_data_t exp);
    if (got !== exp) begin
      $display("ERROR: %s is 0x%h, expected 0x%h at time %0t", name, got, exp, $time);
      $display("Test failed");
      $fatal(1, "Read data mismatch");
    end
  endtask

  task automatic drive_idle();
    we_i    = '0;
    wreq_i  = '0;
    re_i    = '0;
    raddr_i = '0;
  endtask

  // Only four registers per bank are used, so collisions are frequent
  task automatic drive_random();
    logic [31:0] r;
    for (int unsigned p = 0; p < NrWritePorts; p++) begin
      r = next_random();
      we_i[p]             = (r[1:0] != 2'b00);
      wreq_i[p].addr.vreg = vreg_idx_t'(r[3:2]);
      wreq_i[p].addr.bank = bank_idx_t'(r[5:4]);
      wreq_i[p].be        = vreg_be_t'(r[13:6]);
      wreq_i[p].data      = {next_random(), next_random()};
    end
    for (int unsigned p = 0; p < NrReadPorts; p++) begin
      r = next_random();
      re_i[p]         = (r[1:0] != 2'b00);
      raddr_i[p].vreg = vreg_idx_t'(r[3:2]);
      raddr_i[p].bank = bank_idx_t'(r[5:4]);
    end
  endtask

  // Called between edges, when the combinational outputs have settled
  task automatic check_cycle(output logic [NrWritePorts-1:0] exp_wvalid);
    logic [NrReadPorts-1:0] exp_rvalid;
    exp_wvalid = model_wgrant(we_i, wreq_i);
    exp_rvalid = model_rgrant(re_i, raddr_i);
    check_grant("wvalid_o", NrReadPorts'(wvalid_o), NrReadPorts'(exp_wvalid));
    check_grant("rvalid_o", rvalid_o, exp_rvalid);
    for (int unsigned p = 0; p < NrReadPorts; p++) begin
      check_data($sformatf("rdata_o[%0d]", p), rdata_o[p],
                 model_rdata(exp_rvalid[p], raddr_i[p]));
    end
    if (exp_wvalid != we_i) begin
      wr_conflicts++;
    end
    if (exp_rvalid != re_i) begin
      rd_refusals++;
    end
    for (int unsigned rp = 0; rp < NrReadPorts; rp++) begin
      for (int unsigned wp = 0; wp < NrWritePorts; wp++) begin
        if (exp_rvalid[rp] && exp_wvalid[wp] && (raddr_i[rp] == wreq_i[wp].addr)) begin
          same_word++;
        end
      end
    end
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin : stimulus
    logic [NrWritePorts-1:0] exp_wvalid;
    logic [NrReadPorts-1:0]  sweep_rvalid;
    rng_state    = 32'd69;
    wr_conflicts = 0;
    rd_refusals  = 0;
    same_word    = 0;
    sweep_rvalid = '0;
    sweep_rvalid[VFU_VS2_RD] = 1'b1;
    model_clear();
    rst_i = 1'b1;
    drive_idle();
    repeat (ResetCycles) @(posedge clk_i);
    #(DriveDelay);
    rst_i = 1'b0;

    // Every word reads zero straight after reset
    for (int unsigned w = 0; w < SweepCycles; w++) begin
      drive_idle();
      re_i[VFU_VS2_RD]    = 1'b1;
      raddr_i[VFU_VS2_RD] = vreg_addr_t'(w[6:0]);
      @(negedge clk_i);
      check_grant("rvalid_o", rvalid_o, sweep_rvalid);
      check_data("rdata_o[0]", rdata_o[VFU_VS2_RD], '0);
      @(posedge clk_i);
      #(DriveDelay);
    end

    for (int unsigned n = 0; n < NumCycles; n++) begin
      drive_random();
      @(negedge clk_i);
      check_cycle(exp_wvalid);
      @(posedge clk_i);
      model_write(exp_wvalid, wreq_i);
      #(DriveDelay);
    end
    drive_idle();

    $display("Refused writes %0d, refused reads %0d, same-word accesses %0d",
             wr_conflicts, rd_refusals, same_word);
    if ((wr_conflicts > 0) && (rd_refusals > 0) && (same_word > 0)) begin
      $display("Test completed successfully");
      $finish;
    end else begin
      $display("Random traffic never produced a conflict or a same-word access");
      $display("Test failed");
      $fatal(1, "Stimulus missed a required case");
    end
  end

  initial begin : watchdog
    #(TimeoutTime);
    $display("Test failed");
    $fatal(1, "Watchdog expired before the run ended");
  end

endmodule : vrf_tb

// ==== project.f ====
+incdir+dv
source/vrf_pkg.sv
source/vreg_bank.sv
source/vrf_write_arb.sv
source/vrf_read_arb.sv
source/vrf.sv
dv/vrf_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the register file testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing \
  -f project.f \
  --top-module vrf_tb \
  -o vrf_sim

./obj_dir/vrf_sim
